// ==== fmul_pkg.sv ====
package fmul_pkg;

    ////////////////////
    // Binary16 format.
    ////////////////////
    localparam int EXP_BITS = 5;
    localparam int MAN_BITS = 10;
    localparam int FP_W     = 16;
    localparam int BIAS     = 15;
    localparam int PROD_W   = 22;   // 11 x 11 bit mantissa product.

    localparam logic [FP_W-1:0] QNAN = 16'h7E00;

    ////////////////////
    // Exception flags.
    ////////////////////
    localparam int FLAG_W  = 5;
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rnd_mode_e;

    typedef enum logic {
        OP_MUL  = 1'b0,
        OP_NMUL = 1'b1
    } fmul_op_e;

    // Result classes that bypass the arithmetic.
    typedef enum logic [1:0] {
        SPEC_NONE = 2'd0,
        SPEC_NAN  = 2'd1,
        SPEC_INF  = 2'd2,
        SPEC_ZERO = 2'd3
    } spec_e;

endpackage

// ==== fmul_unpack.sv ====
`timescale 1ns/1ps

module fmul_unpack (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          en_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  logic [fmul_pkg::FP_W-1:0]     op_a_i,
    input  logic [fmul_pkg::FP_W-1:0]     op_b_i,
    input  fmul_pkg::fmul_op_e            op_i,
    input  fmul_pkg::rnd_mode_e           rnd_i,
    output logic                          s1_valid_o,
    output logic [fmul_pkg::MAN_BITS:0]   s1_mant_a_o,
    output logic [fmul_pkg::MAN_BITS:0]   s1_mant_b_o,
    output logic signed [7:0]             s1_exp_o,
    output logic                          s1_sign_o,
    output fmul_pkg::rnd_mode_e           s1_rnd_o,
    output fmul_pkg::spec_e               s1_spec_o,
    output logic                          s1_spec_sign_o,
    output logic                          s1_nv_o
);

    // Leading zeros of an 11 bit mantissa.
    function automatic logic [3:0] lzc11(input logic [fmul_pkg::MAN_BITS:0] m);
        logic [3:0] n;
        n = 4'd11;
        for (int i = 0; i <= fmul_pkg::MAN_BITS; i++) begin
            if (m[i]) n = 4'(fmul_pkg::MAN_BITS - i);   // Highest set bit wins.
        end
        return n;
    endfunction

    logic [fmul_pkg::EXP_BITS-1:0] exp_a, exp_b;
    logic [fmul_pkg::MAN_BITS-1:0] man_a, man_b;
    logic exp_max_a, exp_max_b, exp_nz_a, exp_nz_b;
    logic zero_a, zero_b, inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;
    logic [fmul_pkg::MAN_BITS:0] raw_a, raw_b;
    logic [3:0] lz_a, lz_b;
    logic signed [7:0] exp_sum;
    logic sign, inv;
    fmul_pkg::spec_e spec;

    assign in_ready_o = en_i;

    assign exp_a = op_a_i[fmul_pkg::FP_W-2 -: fmul_pkg::EXP_BITS];
    assign exp_b = op_b_i[fmul_pkg::FP_W-2 -: fmul_pkg::EXP_BITS];
    assign man_a = op_a_i[fmul_pkg::MAN_BITS-1:0];
    assign man_b = op_b_i[fmul_pkg::MAN_BITS-1:0];

    ////////////////////
    // Classification.
    ////////////////////
    assign exp_nz_a  = |exp_a;
    assign exp_nz_b  = |exp_b;
    assign exp_max_a = &exp_a;
    assign exp_max_b = &exp_b;
    assign zero_a    = !exp_nz_a && (man_a == '0);
    assign zero_b    = !exp_nz_b && (man_b == '0);
    assign inf_a     = exp_max_a && (man_a == '0);
    assign inf_b     = exp_max_b && (man_b == '0);
    assign nan_a     = exp_max_a && (man_a != '0);
    assign nan_b     = exp_max_b && (man_b != '0);
    assign snan_a    = nan_a && !man_a[fmul_pkg::MAN_BITS-1];  // Quiet bit clear.
    assign snan_b    = nan_b && !man_b[fmul_pkg::MAN_BITS-1];
    assign inv       = (inf_a && zero_b) || (zero_a && inf_b);

    assign sign = op_a_i[fmul_pkg::FP_W-1] ^ op_b_i[fmul_pkg::FP_W-1]
                ^ (op_i == fmul_pkg::OP_NMUL);

    always_comb begin
        if (nan_a || nan_b || inv) spec = fmul_pkg::SPEC_NAN;
        else if (inf_a || inf_b)   spec = fmul_pkg::SPEC_INF;
        else if (zero_a || zero_b) spec = fmul_pkg::SPEC_ZERO;
        else                       spec = fmul_pkg::SPEC_NONE;
    end

    // Subnormals use exponent 1 and get normalized by the leading-zero count.
    assign raw_a = {exp_nz_a, man_a};
    assign raw_b = {exp_nz_b, man_b};
    assign lz_a  = lzc11(raw_a);
    assign lz_b  = lzc11(raw_b);

    assign exp_sum = $signed({3'b0, exp_a | {4'b0, !exp_nz_a}})
                   + $signed({3'b0, exp_b | {4'b0, !exp_nz_b}})
                   - 8'sd15
                   - $signed({4'b0, lz_a})
                   - $signed({4'b0, lz_b});

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_o <= 1'b0;
        end else if (en_i) begin
            s1_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            s1_mant_a_o    <= raw_a << lz_a;
            s1_mant_b_o    <= raw_b << lz_b;
            s1_exp_o       <= exp_sum;
            s1_sign_o      <= sign;
            s1_rnd_o       <= rnd_i;
            s1_spec_o      <= spec;
            s1_spec_sign_o <= sign;
            s1_nv_o        <= snan_a || snan_b || inv;
        end
    end

    a_legal_cmd: assert property (@(posedge clk) disable iff (rst_i)
        in_valid_i |-> (op_i inside {fmul_pkg::OP_MUL, fmul_pkg::OP_NMUL})
                    && (rnd_i inside {fmul_pkg::RM_RNE, fmul_pkg::RM_RTZ, fmul_pkg::RM_RDN,
                                      fmul_pkg::RM_RUP, fmul_pkg::RM_RMM}));

endmodule

// ==== fmul_mant_mul.sv ====
`timescale 1ns/1ps

module fmul_mant_mul (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          en_i,
    input  logic                          s1_valid_i,
    input  logic [fmul_pkg::MAN_BITS:0]   s1_mant_a_i,
    input  logic [fmul_pkg::MAN_BITS:0]   s1_mant_b_i,
    input  logic signed [7:0]             s1_exp_i,
    input  logic                          s1_sign_i,
    input  fmul_pkg::rnd_mode_e           s1_rnd_i,
    input  fmul_pkg::spec_e               s1_spec_i,
    input  logic                          s1_spec_sign_i,
    input  logic                          s1_nv_i,
    output logic                          s2_valid_o,
    output logic [fmul_pkg::PROD_W-1:0]   s2_prod_o,
    output logic signed [7:0]             s2_exp_o,
    output logic                          s2_sign_o,
    output fmul_pkg::rnd_mode_e           s2_rnd_o,
    output fmul_pkg::spec_e               s2_spec_o,
    output logic                          s2_spec_sign_o,
    output logic                          s2_nv_o
);

    // One radix-4 Booth partial product, two's complement modulo 2^PROD_W.
    function automatic logic [fmul_pkg::PROD_W-1:0] booth_pp(
        input logic [2:0]                  code,
        input logic [fmul_pkg::MAN_BITS:0] a
    );
        logic [fmul_pkg::PROD_W-1:0] m;
        m = {{(fmul_pkg::PROD_W-fmul_pkg::MAN_BITS-1){1'b0}}, a};
        case (code)
            3'b001, 3'b010: return m;
            3'b011:         return m << 1;
            3'b100:         return -(m << 1);
            3'b101, 3'b110: return -m;
            default:        return '0;
        endcase
    endfunction

    logic [12:0] booth_b;   // Zero padded so the top digit is never negative.
    logic [fmul_pkg::PROD_W-1:0] prod;

    assign booth_b = {1'b0, s1_mant_b_i, 1'b0};

    always_comb begin
        prod = '0;
        for (int i = 0; i < 6; i++) begin
            prod = prod + (booth_pp(booth_b[2*i+2 -: 3], s1_mant_a_i) << (2 * i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s2_valid_o <= 1'b0;
        end else if (en_i) begin
            s2_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            s2_prod_o      <= prod;
            s2_exp_o       <= s1_exp_i;
            s2_sign_o      <= s1_sign_i;
            s2_rnd_o       <= s1_rnd_i;
            s2_spec_o      <= s1_spec_i;
            s2_spec_sign_o <= s1_spec_sign_i;
            s2_nv_o        <= s1_nv_i;
        end
    end

    // Normalized inputs keep the product in [1, 4).
    a_prod_norm: assert property (@(posedge clk) disable iff (rst_i)
        (s2_valid_o && s2_spec_o == fmul_pkg::SPEC_NONE) |-> (s2_prod_o[21] || s2_prod_o[20]));

endmodule

// ==== fmul_round.sv ====
`timescale 1ns/1ps

module fmul_round (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          s2_valid_i,
    input  logic [fmul_pkg::PROD_W-1:0]   s2_prod_i,
    input  logic signed [7:0]             s2_exp_i,
    input  logic                          s2_sign_i,
    input  fmul_pkg::rnd_mode_e           s2_rnd_i,
    input  fmul_pkg::spec_e               s2_spec_i,
    input  logic                          s2_spec_sign_i,
    input  logic                          s2_nv_i,
    input  logic                          out_ready_i,
    output logic                          out_valid_o,
    output logic [fmul_pkg::FP_W-1:0]     result_o,
    output logic [fmul_pkg::FLAG_W-1:0]   flags_o,
    output logic                          pipe_en_o
);

    function automatic logic rnd_up(
        input fmul_pkg::rnd_mode_e rm,
        input logic                sign,
        input logic                lsb,
        input logic                guard,
        input logic                sticky
    );
        case (rm)
            fmul_pkg::RM_RNE: return guard && (sticky || lsb);
            fmul_pkg::RM_RDN: return (guard || sticky) && sign;
            fmul_pkg::RM_RUP: return (guard || sticky) && !sign;
            fmul_pkg::RM_RMM: return guard;
            default:          return 1'b0;
        endcase
    endfunction

    logic [fmul_pkg::PROD_W-1:0] norm, shifted, lost_mask;
    logic signed [7:0] exp_n, sh_full, exp_base;
    logic [4:0] sh;
    logic sub, guard, sticky, inexact, up, unb_carry, tiny, ovf, to_inf;
    logic [fmul_pkg::MAN_BITS:0] mant;
    logic [11:0] rounded;
    logic [17:0] packed_sum;
    logic [7:0] exp_r;
    logic [fmul_pkg::FP_W-1:0] res_c;
    logic [fmul_pkg::FLAG_W-1:0] flags_c;

    assign pipe_en_o = !(out_valid_o && !out_ready_i);

    ////////////////////
    // Normalize.
    ////////////////////
    assign norm  = s2_prod_i[21] ? s2_prod_i : s2_prod_i << 1;
    assign exp_n = s2_exp_i + $signed({7'b0, s2_prod_i[21]});
    assign sub   = exp_n < 8'sd1;

    // Right shift into the subnormal range, lost bits go to sticky.
    assign sh_full   = 8'sd1 - exp_n;
    assign sh        = !sub ? 5'd0 : (sh_full > 8'sd22) ? 5'd22 : sh_full[4:0];
    assign shifted   = norm >> sh;
    assign lost_mask = ~({fmul_pkg::PROD_W{1'b1}} << sh);

    assign mant    = shifted[21:11];
    assign guard   = shifted[10];
    assign sticky  = (|shifted[9:0]) || (|(norm & lost_mask));
    assign inexact = guard || sticky;

    ////////////////////
    // Round.
    ////////////////////
    assign up      = rnd_up(s2_rnd_i, s2_sign_i, mant[0], guard, sticky);
    assign rounded = {1'b0, mant} + {11'b0, up};

    // The hidden bit carries into the exponent field on its own.
    assign exp_base   = sub ? 8'sd0 : exp_n - 8'sd1;
    assign packed_sum = {exp_base, 10'b0} + {6'b0, rounded};
    assign exp_r      = packed_sum[17:10];
    assign ovf        = exp_r >= 8'd31;

    // Tininess after rounding, as if the exponent were unbounded.
    assign unb_carry = (&norm[21:11])
                    && rnd_up(s2_rnd_i, s2_sign_i, norm[11], norm[10], |norm[9:0]);
    assign tiny      = sub && !(exp_n == 8'sd0 && unb_carry);

    assign to_inf = (s2_rnd_i == fmul_pkg::RM_RNE) || (s2_rnd_i == fmul_pkg::RM_RMM)
                 || (s2_rnd_i == fmul_pkg::RM_RDN && s2_sign_i)
                 || (s2_rnd_i == fmul_pkg::RM_RUP && !s2_sign_i);

    always_comb begin
        flags_c = '0;
        case (s2_spec_i)
            fmul_pkg::SPEC_NAN: begin
                res_c                     = fmul_pkg::QNAN;
                flags_c[fmul_pkg::FLAG_NV] = s2_nv_i;
            end
            fmul_pkg::SPEC_INF:  res_c = {s2_spec_sign_i, 5'h1F, 10'h000};
            fmul_pkg::SPEC_ZERO: res_c = {s2_spec_sign_i, 15'h0000};
            default: begin
                if (ovf) begin
                    res_c = to_inf ? {s2_sign_i, 5'h1F, 10'h000}    // Infinity.
                                   : {s2_sign_i, 5'h1E, 10'h3FF};   // Largest finite.
                    flags_c[fmul_pkg::FLAG_OF] = 1'b1;
                    flags_c[fmul_pkg::FLAG_NX] = 1'b1;
                end else begin
                    res_c = {s2_sign_i, exp_r[4:0], packed_sum[9:0]};
                    flags_c[fmul_pkg::FLAG_UF] = tiny && inexact;
                    flags_c[fmul_pkg::FLAG_NX] = inexact;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (pipe_en_o) begin
            out_valid_o <= s2_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en_o) begin
            result_o <= res_c;
            flags_o  <= flags_c;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> ($stable(result_o) && $stable(flags_o)));

endmodule

// ==== fmul_top.sv ====
`timescale 1ns/1ps

module fmul_top (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  logic [fmul_pkg::FP_W-1:0]     op_a_i,
    input  logic [fmul_pkg::FP_W-1:0]     op_b_i,
    input  fmul_pkg::fmul_op_e            op_i,
    input  fmul_pkg::rnd_mode_e           rnd_i,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output logic [fmul_pkg::FP_W-1:0]     result_o,
    output logic [fmul_pkg::FLAG_W-1:0]   flags_o
);

    logic pipe_en;   // One stall signal freezes all three stages.

    logic                          s1_valid, s1_sign, s1_spec_sign, s1_nv;
    logic [fmul_pkg::MAN_BITS:0]   s1_mant_a, s1_mant_b;
    logic signed [7:0]             s1_exp;
    fmul_pkg::rnd_mode_e           s1_rnd;
    fmul_pkg::spec_e               s1_spec;

    logic                          s2_valid, s2_sign, s2_spec_sign, s2_nv;
    logic [fmul_pkg::PROD_W-1:0]   s2_prod;
    logic signed [7:0]             s2_exp;
    fmul_pkg::rnd_mode_e           s2_rnd;
    fmul_pkg::spec_e               s2_spec;

    fmul_unpack i_fmul_unpack (
        .clk            (clk),
        .rst_i          (rst_i),
        .en_i           (pipe_en),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .op_a_i         (op_a_i),
        .op_b_i         (op_b_i),
        .op_i           (op_i),
        .rnd_i          (rnd_i),
        .s1_valid_o     (s1_valid),
        .s1_mant_a_o    (s1_mant_a),
        .s1_mant_b_o    (s1_mant_b),
        .s1_exp_o       (s1_exp),
        .s1_sign_o      (s1_sign),
        .s1_rnd_o       (s1_rnd),
        .s1_spec_o      (s1_spec),
        .s1_spec_sign_o (s1_spec_sign),
        .s1_nv_o        (s1_nv)
    );

    fmul_mant_mul i_fmul_mant_mul (
        .clk            (clk),
        .rst_i          (rst_i),
        .en_i           (pipe_en),
        .s1_valid_i     (s1_valid),
        .s1_mant_a_i    (s1_mant_a),
        .s1_mant_b_i    (s1_mant_b),
        .s1_exp_i       (s1_exp),
        .s1_sign_i      (s1_sign),
        .s1_rnd_i       (s1_rnd),
        .s1_spec_i      (s1_spec),
        .s1_spec_sign_i (s1_spec_sign),
        .s1_nv_i        (s1_nv),
        .s2_valid_o     (s2_valid),
        .s2_prod_o      (s2_prod),
        .s2_exp_o       (s2_exp),
        .s2_sign_o      (s2_sign),
        .s2_rnd_o       (s2_rnd),
        .s2_spec_o      (s2_spec),
        .s2_spec_sign_o (s2_spec_sign),
        .s2_nv_o        (s2_nv)
    );

    fmul_round i_fmul_round (
        .clk            (clk),
        .rst_i          (rst_i),
        .s2_valid_i     (s2_valid),
        .s2_prod_i      (s2_prod),
        .s2_exp_i       (s2_exp),
        .s2_sign_i      (s2_sign),
        .s2_rnd_i       (s2_rnd),
        .s2_spec_i      (s2_spec),
        .s2_spec_sign_i (s2_spec_sign),
        .s2_nv_i        (s2_nv),
        .out_ready_i    (out_ready_i),
        .out_valid_o    (out_valid_o),
        .result_o       (result_o),
        .flags_o        (flags_o),
        .pipe_en_o      (pipe_en)
    );

endmodule

// ==== tb_fmul_ref.svh ====
`ifndef TB_FMUL_REF_SVH
`define TB_FMUL_REF_SVH

// Rounds pr right by s bits. Returns {inexact, 12 bit significand}.
function automatic logic [12:0] round_right(input longint pr, input int s,
                                            input fmul_pkg::rnd_mode_e rm, input logic sign);
    longint m;
    logic g, st, up;
    if (s <= 0) return {1'b0, 12'(pr << (-s))};   // Exact, only widens.
    m  = pr >> s;
    g  = ((pr >> (s - 1)) & 64'd1) != 64'd0;
    st = (pr & ((64'd1 << (s - 1)) - 64'd1)) != 64'd0;
    case (rm)
        fmul_pkg::RM_RNE: up = g && (st || m[0]);
        fmul_pkg::RM_RTZ: up = 1'b0;
        fmul_pkg::RM_RDN: up = (g || st) && sign;
        fmul_pkg::RM_RUP: up = (g || st) && !sign;
        default:          up = g;
    endcase
    m = m + (up ? 64'sd1 : 64'sd0);
    return {g || st, 12'(m)};
endfunction

// Expected {flags, result} of one multiply.
function automatic logic [fmul_pkg::FLAG_W+fmul_pkg::FP_W-1:0] ref_fmul(
    input logic [15:0] a, input logic [15:0] b,
    input fmul_pkg::fmul_op_e op, input fmul_pkg::rnd_mode_e rm);
    int ea, eb, e, p, s, bexp;
    longint sig_a, sig_b, pr;
    logic sign, nan_a, nan_b, inf_a, inf_b, zero_a, zero_b, inv, tiny, to_max;
    logic [12:0] r, ru;
    logic [fmul_pkg::FLAG_W-1:0] fl;
    fl     = '0;
    sign   = a[15] ^ b[15] ^ (op == fmul_pkg::OP_NMUL);
    nan_a  = (a[14:10] == 5'h1F) && (a[9:0] != 10'h0);
    nan_b  = (b[14:10] == 5'h1F) && (b[9:0] != 10'h0);
    inf_a  = (a[14:10] == 5'h1F) && (a[9:0] == 10'h0);
    inf_b  = (b[14:10] == 5'h1F) && (b[9:0] == 10'h0);
    zero_a = a[14:0] == 15'h0;
    zero_b = b[14:0] == 15'h0;
    inv    = (inf_a && zero_b) || (zero_a && inf_b);
    if (nan_a || nan_b || inv) begin
        fl[fmul_pkg::FLAG_NV] = (nan_a && !a[9]) || (nan_b && !b[9]) || inv;
        return {fl, fmul_pkg::QNAN};
    end
    if (inf_a || inf_b) return {fl, sign, 5'h1F, 10'h0};
    if (zero_a || zero_b) return {fl, sign, 15'h0};

    // Each operand is sig * 2^(e - 10).
    ea    = (a[14:10] == 5'd0) ? -14 : int'(a[14:10]) - 15;
    eb    = (b[14:10] == 5'd0) ? -14 : int'(b[14:10]) - 15;
    sig_a = (a[14:10] == 5'd0) ? longint'(a[9:0]) : longint'(a[9:0]) + 64'sd1024;
    sig_b = (b[14:10] == 5'd0) ? longint'(b[9:0]) : longint'(b[9:0]) + 64'sd1024;
    pr    = sig_a * sig_b;
    p     = 0;
    for (int i = 0; i < 22; i++) begin
        if (pr[i]) p = i;
    end
    e = ea + eb - 20 + p;   // Exponent of the leading one.

    ru   = round_right(pr, p - 10, rm, sign);
    tiny = (ru[11] ? e + 1 : e) < -14;
    s    = (e < -14) ? p - 10 + (-14 - e) : p - 10;
    e    = (e < -14) ? -14 : e;
    r    = round_right(pr, s, rm, sign);
    bexp = r[11] ? e + 16 : (r[10] ? e + 15 : 0);

    if (bexp >= 31) begin
        // Toward zero, or away from the sign, stops at the largest finite value.
        to_max = (rm == fmul_pkg::RM_RTZ) || (rm == fmul_pkg::RM_RDN && !sign)
              || (rm == fmul_pkg::RM_RUP && sign);
        fl[fmul_pkg::FLAG_OF] = 1'b1;
        fl[fmul_pkg::FLAG_NX] = 1'b1;
        return to_max ? {fl, sign, 5'h1E, 10'h3FF} : {fl, sign, 5'h1F, 10'h0};
    end
    fl[fmul_pkg::FLAG_NX] = r[12];
    fl[fmul_pkg::FLAG_UF] = tiny && r[12];
    return {fl, sign, 5'(bexp), r[9:0]};
endfunction

`endif

// ==== tb_fmul.sv ====
`timescale 1ns/1ps

module tb_fmul;

    localparam int N_NORMAL  = 400;
    localparam int N_SPECIAL = 144;   // 12 x 12 operand pairs.
    localparam int N_SUBNORM = 300;
    localparam int N_OVF     = 100;
    localparam int N_NMUL    = 200;
    localparam int N_B2B     = 100;
    localparam int N_RAND_HS = 200;
    localparam int N_TOTAL   = N_NORMAL + N_SPECIAL + N_SUBNORM + N_OVF + N_NMUL
                             + N_B2B + N_RAND_HS;
    localparam int DRAIN_MAX = 100;   // Cycles allowed for the pipe to empty.

    localparam logic [15:0] SPEC_VALS [12] = '{
        16'h7E00, 16'hFE55, 16'h7C01, 16'hFD00,   // Quiet and signalling NaNs.
        16'h7C00, 16'hFC00, 16'h0000, 16'h8000,
        16'h3C00, 16'hC880, 16'h0001, 16'h7BFF
    };

    logic clk;
    logic rst_i, in_valid_i, in_ready_o, out_valid_o;
    logic out_ready_i = 1'b1;
    logic [fmul_pkg::FP_W-1:0] op_a_i, op_b_i, result_o;
    fmul_pkg::fmul_op_e op_i;
    fmul_pkg::rnd_mode_e rnd_i;
    logic [fmul_pkg::FLAG_W-1:0] flags_o;

    int seed;
    int errors = 0;
    int cycle = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    string test_name = "reset";
    bit lat_chk = 1'b1;
    bit rand_ready = 1'b0;
    bit ready_pat [256];
    logic [fmul_pkg::FLAG_W+fmul_pkg::FP_W-1:0] exp_q [$];
    int acc_q [$];

    `include "tb_fmul_ref.svh"

    fmul_top i_fmul_top (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_a_i      (op_a_i),
        .op_b_i      (op_b_i),
        .op_i        (op_i),
        .rnd_i       (rnd_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .flags_o     (flags_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Checks.
    ////////////////////
    task automatic check_result(input string name, input logic [fmul_pkg::FP_W-1:0] expected,
                                input logic [fmul_pkg::FP_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s result: expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input logic [fmul_pkg::FLAG_W-1:0] expected,
                               input logic [fmul_pkg::FLAG_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s flags: expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    // Accept monitor. Expected values are queued in input order.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst_i && in_valid_i && in_ready_o) begin
            exp_q.push_back(ref_fmul(op_a_i, op_b_i, op_i, rnd_i));
            acc_q.push_back(cycle);
        end
    end

    always @(posedge clk) begin
        logic [fmul_pkg::FLAG_W+fmul_pkg::FP_W-1:0] e;
        int lat;
        if (!rst_i && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: %s: result came out with no input waiting for it", test_name);
                errors++;
            end else begin
                e   = exp_q.pop_front();
                lat = cycle - acc_q.pop_front();
                check_result(test_name, e[fmul_pkg::FP_W-1:0], result_o);
                check_flags(test_name, e[fmul_pkg::FP_W +: fmul_pkg::FLAG_W], flags_o);
                if (lat_chk && lat != 3) begin
                    $display("ERROR: %s: result took %0d cycles instead of 3", test_name, lat);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        out_ready_i <= rand_ready ? ready_pat[cycle % 256] : 1'b1;
    end

    initial begin
        repeat (N_TOTAL * 20 + 200) @(posedge clk);
        $display("ERROR: watchdog expired, results stopped arriving");
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // Stimulus helpers.
    ////////////////////
    function automatic logic [15:0] rand_fp(input int lo, input int hi);
        logic [4:0] e;
        e = 5'(lo + int'({$random(seed)} % (hi - lo + 1)));
        return {1'($random(seed)), e, 10'($random(seed))};
    endfunction

    function automatic fmul_pkg::rnd_mode_e mode(input int i);
        return fmul_pkg::rnd_mode_e'(3'(i % 5));
    endfunction

    task automatic send(input logic [15:0] a, input logic [15:0] b,
                        input fmul_pkg::fmul_op_e op, input fmul_pkg::rnd_mode_e rm);
        in_valid_i <= 1'b1;
        op_a_i     <= a;
        op_b_i     <= b;
        op_i       <= op;
        rnd_i      <= rm;
        @(posedge clk);
        if (lat_chk && !in_ready_o) begin
            $display("ERROR: %s: input stalled while the output side was ready", test_name);
            errors++;
        end
        while (!in_ready_o) @(posedge clk);   // Hold until taken.
        in_valid_i <= 1'b0;
    endtask

    task automatic finish_test(input int items, input int err_before);
        int waited;
        waited = 0;
        @(posedge clk);
        while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %s: %0d expected results never came out", test_name, exp_q.size());
            errors++;
            exp_q.delete();
            acc_q.delete();
        end
        if (errors == err_before) begin
            pass_cnt++;
            $display("%s: %0d items, ok", test_name, items);
        end else begin
            fail_cnt++;
            $display("%s: %0d items, %0d errors", test_name, items, errors - err_before);
        end
    endtask

    initial begin
        int err0;
        logic [15:0] a, b;
        seed        = 61288;
        rst_i      <= 1'b1;
        in_valid_i <= 1'b0;
        op_a_i     <= '0;
        op_b_i     <= '0;
        op_i       <= fmul_pkg::OP_MUL;
        rnd_i      <= fmul_pkg::RM_RNE;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        test_name = "normal";
        err0 = errors;
        for (int i = 0; i < N_NORMAL; i++) begin
            send(rand_fp(8, 22), rand_fp(8, 22), fmul_pkg::OP_MUL, mode(i));
        end
        finish_test(N_NORMAL, err0);

        test_name = "special";
        err0 = errors;
        for (int i = 0; i < 12; i++) begin
            for (int j = 0; j < 12; j++) begin
                send(SPEC_VALS[i], SPEC_VALS[j], fmul_pkg::OP_MUL, mode(i + j));
            end
        end
        finish_test(N_SPECIAL, err0);

        test_name = "subnormal";
        err0 = errors;
        for (int m = 0; m < 5; m++) begin
            send(16'h3BFF, 16'h0400, fmul_pkg::OP_MUL, mode(m));   // Rounds up into 2^-14.
            send(16'hBBFF, 16'h0400, fmul_pkg::OP_MUL, mode(m));
            send(16'h3800, 16'h0401, fmul_pkg::OP_MUL, mode(m));   // Halfway case.
            send(16'h0155, 16'h3E00, fmul_pkg::OP_MUL, mode(m));
        end
        for (int i = 0; i < 140; i++) begin
            a = {1'($random(seed)), 5'd0, 10'($random(seed))};
            send(a, rand_fp(5, 25), fmul_pkg::OP_MUL, mode(i));
        end
        for (int i = 0; i < 140; i++) begin
            send(rand_fp(1, 14), rand_fp(1, 14), fmul_pkg::OP_MUL, mode(i));
        end
        finish_test(N_SUBNORM, err0);

        test_name = "overflow";
        err0 = errors;
        for (int i = 0; i < N_OVF; i++) begin
            send(rand_fp(23, 30), rand_fp(23, 30), fmul_pkg::OP_MUL, mode(i));
        end
        finish_test(N_OVF, err0);

        test_name = "nmul";
        err0 = errors;
        for (int i = 0; i < N_NMUL / 2; i++) begin
            a = (i % 4 == 0) ? SPEC_VALS[{$random(seed)} % 12] : rand_fp(1, 30);
            b = rand_fp(1, 30);
            send(a, b, fmul_pkg::OP_MUL, mode(i));
            send(a, b, fmul_pkg::OP_NMUL, mode(i));
        end
        finish_test(N_NMUL, err0);

        test_name = "back_to_back";
        err0 = errors;
        for (int i = 0; i < N_B2B; i++) begin
            send(rand_fp(1, 30), rand_fp(1, 30), fmul_pkg::fmul_op_e'(1'($random(seed))), mode(i));
        end
        finish_test(N_B2B, err0);

        test_name = "random_handshake";
        err0 = errors;
        for (int i = 0; i < 256; i++) ready_pat[i] = 1'($random(seed));
        lat_chk    = 1'b0;
        rand_ready = 1'b1;
        for (int i = 0; i < N_RAND_HS; i++) begin
            repeat ({$random(seed)} % 3) @(posedge clk);
            send(rand_fp(1, 30), rand_fp(1, 30), fmul_pkg::fmul_op_e'(1'($random(seed))), mode(i));
        end
        rand_ready = 1'b0;
        finish_test(N_RAND_HS, err0);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (errors == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
fmul_pkg.sv
fmul_unpack.sv
fmul_mant_mul.sv
fmul_round.sv
fmul_top.sv
tb_fmul.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps --top-module tb_fmul -f compile.f -o tb_fmul
./obj_dir/tb_fmul > sim.log 2>&1
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
